//--- design/avr_isa_pkg.sv
package avr_isa_pkg;

	// Decoded operation
	typedef enum logic [4:0]
	{
		OP_NOP,
		OP_ADD,
		OP_ADC,
		OP_SUB,
		OP_SBC,
		OP_AND,
		OP_OR,
		OP_EOR,
		OP_MOV,
		OP_INC,
		OP_DEC,
		OP_LDI,
		OP_RJMP,
		OP_BRBX,
		OP_IN,
		OP_OUT
	} op_e;

	// Base encodings with all operand fields zero
	localparam logic [15:0] ENC_ADD  = 16'h0C00;
	localparam logic [15:0] ENC_SBC  = 16'h0800;
	localparam logic [15:0] ENC_ADC  = 16'h1C00;
	localparam logic [15:0] ENC_SUB  = 16'h1800;
	localparam logic [15:0] ENC_AND  = 16'h2000;
	localparam logic [15:0] ENC_EOR  = 16'h2400;
	localparam logic [15:0] ENC_OR   = 16'h2800;
	localparam logic [15:0] ENC_MOV  = 16'h2C00;
	localparam logic [15:0] ENC_INC  = 16'h9403;
	localparam logic [15:0] ENC_DEC  = 16'h940A;
	localparam logic [15:0] ENC_IN   = 16'hB000;
	localparam logic [15:0] ENC_OUT  = 16'hB800;
	localparam logic [15:0] ENC_RJMP = 16'hC000;
	localparam logic [15:0] ENC_LDI  = 16'hE000;
	localparam logic [15:0] ENC_BRBS = 16'hF000;
	localparam logic [15:0] ENC_BRBC = 16'hF400;

	// Opcode bits per instruction class
	localparam logic [15:0] MASK_RR  = 16'hFC00; // Two-register ops, BRBS/BRBC
	localparam logic [15:0] MASK_ONE = 16'hFE0F; // INC, DEC
	localparam logic [15:0] MASK_IO  = 16'hF800;
	localparam logic [15:0] MASK_K   = 16'hF000; // LDI, RJMP

	// Operand field positions
	localparam int RD_LSB     = 4;  // Rd at [8:4], LDI uses [7:4]
	localparam int RR_HI      = 9;  // Rr[4], low nibble at [3:0]
	localparam int K_HI_LSB   = 8;  // K[7:4] at [11:8]
	localparam int IO_HI_LSB  = 9;  // A[5:4] at [10:9]
	localparam int BR_OFF_LSB = 3;
	localparam int BR_OFF_W   = 7;
	localparam int JMP_OFF_W  = 12;
	localparam int BR_CLR_BIT = 10; // Set for BRBC

	localparam int SREG_C = 0;
	localparam int SREG_Z = 1;
	localparam int SREG_N = 2;
	localparam int SREG_V = 3;
	localparam int SREG_S = 4;
	localparam int SREG_H = 5;
	localparam int SREG_T = 6;
	localparam int SREG_I = 7;

	localparam logic [5:0] IO_SREG_ADDR = 6'h3F;

endpackage

//--- design/avr_core_pkg.sv
package avr_core_pkg;

	localparam int DATA_W    = 8;
	localparam int INSTR_W   = 16;
	localparam int REG_AW    = 5;
	localparam int PC_W      = 10;
	localparam int IO_AW     = 6;
	localparam int ROM_DEPTH = 1 << PC_W;

	typedef struct packed
	{
		avr_isa_pkg::op_e    op;
		logic [REG_AW-1:0]   rd;
		logic [REG_AW-1:0]   rr;
		logic [DATA_W-1:0]   imm8;
		logic [11:0]         offset12; // Branch offset arrives sign-extended
		logic [2:0]          bsel;
		logic                bset;
		logic [IO_AW-1:0]    io_addr;
	} dec_t;

	// Register write request
	typedef struct packed
	{
		logic                en;
		logic [REG_AW-1:0]   addr;
		logic [DATA_W-1:0]   data;
	} wb_t;

	typedef struct packed
	{
		logic                wr;
		logic                rd;
		logic [IO_AW-1:0]    addr;
		logic [DATA_W-1:0]   dout;
	} io_bus_t;

	typedef enum logic [1:0]
	{
		PH_FETCH,
		PH_EXEC,
		PH_IO
	} phase_e;

endpackage

//--- design/prog_rom.sv
`timescale 1ns/1ps

module prog_rom
(
	input  logic                                ALU_CLK,
	input  logic                                i_we,
	input  logic [avr_core_pkg::PC_W-1:0]       i_waddr,
	input  logic [avr_core_pkg::INSTR_W-1:0]    i_wdata,
	input  logic [avr_core_pkg::PC_W-1:0]       i_raddr,
	output logic [avr_core_pkg::INSTR_W-1:0]    o_rdata
);

	logic [avr_core_pkg::INSTR_W-1:0] mem [avr_core_pkg::ROM_DEPTH];

	always_ff @(posedge ALU_CLK)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
		o_rdata <= mem[i_raddr]; // Valid one cycle after the PC
	end

endmodule

//--- design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
(
	input  logic                                ALU_CLK,
	input  logic                                hclk,
	input  logic                                i_prog_en,
	input  logic                                i_prog_we,
	input  avr_core_pkg::dec_t                  i_dec,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_sreg,
	output logic [avr_core_pkg::PC_W-1:0]       o_pc,
	output avr_core_pkg::phase_e                o_phase,
	output logic                                o_rom_we
);

	logic [avr_core_pkg::PC_W-1:0] pc_inc;
	logic [avr_core_pkg::PC_W-1:0] pc_next;
	logic                          taken;

	assign o_rom_we = i_prog_en & i_prog_we;
	assign pc_inc   = o_pc + avr_core_pkg::PC_W'(1);

	always_comb
	begin
		case (i_dec.op)
			avr_isa_pkg::OP_RJMP: taken = 1'b1;
			avr_isa_pkg::OP_BRBX: taken = (i_sreg[i_dec.bsel] == i_dec.bset);
			default:              taken = 1'b0;
		endcase
		// Offset truncated to the PC width, target wraps
		pc_next = taken ? pc_inc + i_dec.offset12[avr_core_pkg::PC_W-1:0] : pc_inc;
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			o_pc    <= '0;
			o_phase <= avr_core_pkg::PH_FETCH;
		end
		else if (i_prog_en)
		begin
			o_pc    <= '0;
			o_phase <= avr_core_pkg::PH_FETCH;
		end
		else
		begin
			case (o_phase)
				avr_core_pkg::PH_FETCH: o_phase <= avr_core_pkg::PH_EXEC;
				avr_core_pkg::PH_EXEC:
				begin
					o_pc <= pc_next;
					// IN needs an extra bus cycle
					o_phase <= (i_dec.op == avr_isa_pkg::OP_IN) ?
						avr_core_pkg::PH_IO : avr_core_pkg::PH_FETCH;
				end
				default: o_phase <= avr_core_pkg::PH_FETCH;
			endcase
		end
	end

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ps

module instr_decode
(
	input  logic [avr_core_pkg::INSTR_W-1:0]    i_instr,
	output avr_core_pkg::dec_t                  o_dec
);

	logic [avr_core_pkg::INSTR_W-1:0] rr_cls;
	logic [avr_core_pkg::INSTR_W-1:0] one_cls;
	logic [avr_core_pkg::INSTR_W-1:0] io_cls;
	logic [avr_core_pkg::INSTR_W-1:0] k_cls;
	avr_isa_pkg::op_e                 op;

	assign rr_cls  = i_instr & avr_isa_pkg::MASK_RR;
	assign one_cls = i_instr & avr_isa_pkg::MASK_ONE;
	assign io_cls  = i_instr & avr_isa_pkg::MASK_IO;
	assign k_cls   = i_instr & avr_isa_pkg::MASK_K;

	always_comb
	begin
		op = avr_isa_pkg::OP_NOP;
		case (i_instr[15:12])
			4'h0:
			begin
				if (rr_cls == avr_isa_pkg::ENC_ADD) op = avr_isa_pkg::OP_ADD;
				if (rr_cls == avr_isa_pkg::ENC_SBC) op = avr_isa_pkg::OP_SBC;
			end
			4'h1:
			begin
				if (rr_cls == avr_isa_pkg::ENC_ADC) op = avr_isa_pkg::OP_ADC;
				if (rr_cls == avr_isa_pkg::ENC_SUB) op = avr_isa_pkg::OP_SUB;
			end
			4'h2:
			begin
				if (rr_cls == avr_isa_pkg::ENC_AND) op = avr_isa_pkg::OP_AND;
				if (rr_cls == avr_isa_pkg::ENC_EOR) op = avr_isa_pkg::OP_EOR;
				if (rr_cls == avr_isa_pkg::ENC_OR)  op = avr_isa_pkg::OP_OR;
				if (rr_cls == avr_isa_pkg::ENC_MOV) op = avr_isa_pkg::OP_MOV;
			end
			4'h9:
			begin
				if (one_cls == avr_isa_pkg::ENC_INC) op = avr_isa_pkg::OP_INC;
				if (one_cls == avr_isa_pkg::ENC_DEC) op = avr_isa_pkg::OP_DEC;
			end
			4'hB:
			begin
				if (io_cls == avr_isa_pkg::ENC_IN)  op = avr_isa_pkg::OP_IN;
				if (io_cls == avr_isa_pkg::ENC_OUT) op = avr_isa_pkg::OP_OUT;
			end
			4'hC: if (k_cls == avr_isa_pkg::ENC_RJMP) op = avr_isa_pkg::OP_RJMP;
			4'hE: if (k_cls == avr_isa_pkg::ENC_LDI) op = avr_isa_pkg::OP_LDI;
			4'hF:
			begin
				if (rr_cls == avr_isa_pkg::ENC_BRBS || rr_cls == avr_isa_pkg::ENC_BRBC)
					op = avr_isa_pkg::OP_BRBX;
			end
			default: op = avr_isa_pkg::OP_NOP;
		endcase
	end

	always_comb
	begin
		o_dec.op = op;
		if (op == avr_isa_pkg::OP_LDI)
			o_dec.rd = {1'b1, i_instr[avr_isa_pkg::RD_LSB +: 4]}; // r16..r31
		else
			o_dec.rd = i_instr[avr_isa_pkg::RD_LSB +: avr_core_pkg::REG_AW];
		o_dec.rr   = {i_instr[avr_isa_pkg::RR_HI], i_instr[3:0]};
		o_dec.imm8 = {i_instr[avr_isa_pkg::K_HI_LSB +: 4], i_instr[3:0]};
		if (op == avr_isa_pkg::OP_BRBX)
			o_dec.offset12 = {
				{(avr_isa_pkg::JMP_OFF_W - avr_isa_pkg::BR_OFF_W)
					{i_instr[avr_isa_pkg::BR_OFF_LSB + avr_isa_pkg::BR_OFF_W - 1]}},
				i_instr[avr_isa_pkg::BR_OFF_LSB +: avr_isa_pkg::BR_OFF_W]};
		else
			o_dec.offset12 = i_instr[avr_isa_pkg::JMP_OFF_W-1:0];
		o_dec.bsel    = i_instr[2:0];
		o_dec.bset    = ~i_instr[avr_isa_pkg::BR_CLR_BIT]; // BRBS when clear
		o_dec.io_addr = {i_instr[avr_isa_pkg::IO_HI_LSB +: 2], i_instr[3:0]};
	end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file
(
	input  logic                                ALU_CLK,
	input  logic                                hclk,
	input  avr_core_pkg::dec_t                  i_dec,
	input  avr_core_pkg::wb_t                   i_alu_wb,
	input  avr_core_pkg::wb_t                   i_io_wb,
	output logic [avr_core_pkg::DATA_W-1:0]     o_rd_val,
	output logic [avr_core_pkg::DATA_W-1:0]     o_rr_val
);

	logic [avr_core_pkg::DATA_W-1:0] regs [2**avr_core_pkg::REG_AW];
	avr_core_pkg::wb_t               wb;

	// IN data wins, the two never overlap in practice
	assign wb = i_io_wb.en ? i_io_wb : i_alu_wb;

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			for (int i = 0; i < 2**avr_core_pkg::REG_AW; i++)
				regs[i] <= '0;
		end
		else if (wb.en)
			regs[wb.addr] <= wb.data;
	end

	assign o_rd_val = regs[i_dec.rd];
	assign o_rr_val = regs[i_dec.rr];

endmodule

//--- design/alu_sreg.sv
`timescale 1ns/1ps

module alu_sreg
(
	input  logic                                ALU_CLK,
	input  logic                                hclk,
	input  avr_core_pkg::phase_e                i_phase,
	input  avr_core_pkg::dec_t                  i_dec,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_rd_val,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_rr_val,
	output avr_core_pkg::wb_t                   o_wb,
	output logic [avr_core_pkg::DATA_W-1:0]     o_sreg
);

	localparam int W = avr_core_pkg::DATA_W;

	logic         exec;
	logic         cin;
	logic [W:0]   add_w, sub_w;
	logic [4:0]   add_h, sub_h;
	logic [W-1:0] res;
	logic [W-1:0] flags_next;
	logic         upd, wr;
	logic         c_new, h_new, v_new, z_new;

	assign exec = (i_phase == avr_core_pkg::PH_EXEC);
	assign cin  = ((i_dec.op == avr_isa_pkg::OP_ADC) || (i_dec.op == avr_isa_pkg::OP_SBC))
		&& o_sreg[avr_isa_pkg::SREG_C];

	assign add_w = {1'b0, i_rd_val} + {1'b0, i_rr_val} + {{W{1'b0}}, cin};
	assign sub_w = {1'b0, i_rd_val} - {1'b0, i_rr_val} - {{W{1'b0}}, cin}; // Bit W is borrow
	assign add_h = {1'b0, i_rd_val[3:0]} + {1'b0, i_rr_val[3:0]} + {4'b0, cin};
	assign sub_h = {1'b0, i_rd_val[3:0]} - {1'b0, i_rr_val[3:0]} - {4'b0, cin};

	always_comb
	begin
		res   = '0;
		upd   = 1'b0;
		wr    = 1'b0;
		c_new = o_sreg[avr_isa_pkg::SREG_C];
		h_new = o_sreg[avr_isa_pkg::SREG_H];
		v_new = 1'b0;
		case (i_dec.op)
			avr_isa_pkg::OP_ADD, avr_isa_pkg::OP_ADC:
			begin
				res   = add_w[W-1:0];
				c_new = add_w[W];
				h_new = add_h[4];
				v_new = (i_rd_val[W-1] == i_rr_val[W-1]) && (res[W-1] != i_rd_val[W-1]);
				upd   = 1'b1;
				wr    = 1'b1;
			end
			avr_isa_pkg::OP_SUB, avr_isa_pkg::OP_SBC:
			begin
				res   = sub_w[W-1:0];
				c_new = sub_w[W];
				h_new = sub_h[4];
				v_new = (i_rd_val[W-1] != i_rr_val[W-1]) && (res[W-1] != i_rd_val[W-1]);
				upd   = 1'b1;
				wr    = 1'b1;
			end
			avr_isa_pkg::OP_AND, avr_isa_pkg::OP_OR, avr_isa_pkg::OP_EOR:
			begin
				if (i_dec.op == avr_isa_pkg::OP_AND)
					res = i_rd_val & i_rr_val;
				else if (i_dec.op == avr_isa_pkg::OP_OR)
					res = i_rd_val | i_rr_val;
				else
					res = i_rd_val ^ i_rr_val;
				upd = 1'b1;
				wr  = 1'b1;
			end
			avr_isa_pkg::OP_INC:
			begin
				res   = i_rd_val + W'(1);
				v_new = (res == 8'h80);
				upd   = 1'b1;
				wr    = 1'b1;
			end
			avr_isa_pkg::OP_DEC:
			begin
				res   = i_rd_val - W'(1);
				v_new = (res == 8'h7F);
				upd   = 1'b1;
				wr    = 1'b1;
			end
			avr_isa_pkg::OP_MOV:
			begin
				res = i_rr_val;
				wr  = 1'b1;
			end
			avr_isa_pkg::OP_LDI:
			begin
				res = i_dec.imm8;
				wr  = 1'b1;
			end
			default: res = '0;
		endcase

		// SBC only keeps Z when it was already set
		z_new = (res == '0) &&
			((i_dec.op != avr_isa_pkg::OP_SBC) || o_sreg[avr_isa_pkg::SREG_Z]);

		flags_next[avr_isa_pkg::SREG_I] = o_sreg[avr_isa_pkg::SREG_I];
		flags_next[avr_isa_pkg::SREG_T] = o_sreg[avr_isa_pkg::SREG_T];
		flags_next[avr_isa_pkg::SREG_H] = h_new;
		flags_next[avr_isa_pkg::SREG_S] = res[W-1] ^ v_new;
		flags_next[avr_isa_pkg::SREG_V] = v_new;
		flags_next[avr_isa_pkg::SREG_N] = res[W-1];
		flags_next[avr_isa_pkg::SREG_Z] = z_new;
		flags_next[avr_isa_pkg::SREG_C] = c_new;
	end

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
			o_sreg <= '0;
		else if (exec)
		begin
			if (i_dec.op == avr_isa_pkg::OP_OUT && i_dec.io_addr == avr_isa_pkg::IO_SREG_ADDR)
				o_sreg <= i_rd_val;
			else if (upd)
				o_sreg <= flags_next;
		end
	end

	assign o_wb.en   = exec & wr;
	assign o_wb.addr = i_dec.rd;
	assign o_wb.data = res;

endmodule

//--- design/io_port.sv
`timescale 1ns/1ps

module io_port
(
	input  logic                                ALU_CLK,
	input  logic                                hclk,
	input  avr_core_pkg::phase_e                i_phase,
	input  avr_core_pkg::dec_t                  i_dec,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_rd_val,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_io_din,
	output avr_core_pkg::io_bus_t               o_io,
	output avr_core_pkg::wb_t                   o_wb
);

	avr_core_pkg::io_bus_t              io_q;
	logic [avr_core_pkg::REG_AW-1:0]    dest_q; // IN target register

	always_ff @(posedge ALU_CLK or posedge hclk)
	begin
		if (hclk)
		begin
			io_q   <= '0;
			dest_q <= '0;
		end
		else
		begin
			io_q.wr <= 1'b0;
			io_q.rd <= 1'b0;
			if (i_phase == avr_core_pkg::PH_EXEC)
			begin
				if (i_dec.op == avr_isa_pkg::OP_OUT &&
					i_dec.io_addr != avr_isa_pkg::IO_SREG_ADDR)
				begin
					io_q.wr   <= 1'b1;
					io_q.addr <= i_dec.io_addr;
					io_q.dout <= i_rd_val;
				end
				if (i_dec.op == avr_isa_pkg::OP_IN)
				begin
					io_q.rd   <= 1'b1; // High through PH_IO
					io_q.addr <= i_dec.io_addr;
					dest_q    <= i_dec.rd;
				end
			end
		end
	end

	assign o_io = io_q;

	assign o_wb.en   = io_q.rd;
	assign o_wb.addr = dest_q;
	assign o_wb.data = i_io_din;

endmodule

//--- design/avr_core_top.sv
`timescale 1ns/1ps

module avr_core_top
(
	input  logic                                ALU_CLK,
	input  logic                                hclk,
	input  logic                                i_prog_en,
	input  logic                                i_prog_we,
	input  logic [avr_core_pkg::PC_W-1:0]       i_prog_addr,
	input  logic [avr_core_pkg::INSTR_W-1:0]    i_prog_data,
	input  logic [avr_core_pkg::DATA_W-1:0]     i_io_din,
	output avr_core_pkg::io_bus_t               o_io,
	output logic [avr_core_pkg::DATA_W-1:0]     o_sreg,
	output logic [avr_core_pkg::PC_W-1:0]       o_pc,
	output avr_core_pkg::phase_e                o_phase
);

	logic [avr_core_pkg::INSTR_W-1:0] instr;
	logic                             rom_we;
	avr_core_pkg::dec_t               dec;
	logic [avr_core_pkg::DATA_W-1:0]  rd_val;
	logic [avr_core_pkg::DATA_W-1:0]  rr_val;
	avr_core_pkg::wb_t                alu_wb;
	avr_core_pkg::wb_t                io_wb;

	prog_rom u_rom
	(
		.ALU_CLK (ALU_CLK),
		.i_we    (rom_we),
		.i_waddr (i_prog_addr),
		.i_wdata (i_prog_data),
		.i_raddr (o_pc),
		.o_rdata (instr)
	);

	fetch_ctrl u_fetch
	(
		.ALU_CLK   (ALU_CLK),
		.hclk      (hclk),
		.i_prog_en (i_prog_en),
		.i_prog_we (i_prog_we),
		.i_dec     (dec),
		.i_sreg    (o_sreg),
		.o_pc      (o_pc),
		.o_phase   (o_phase),
		.o_rom_we  (rom_we)
	);

	instr_decode u_dec
	(
		.i_instr (instr),
		.o_dec   (dec)
	);

	reg_file u_regs
	(
		.ALU_CLK  (ALU_CLK),
		.hclk     (hclk),
		.i_dec    (dec),
		.i_alu_wb (alu_wb),
		.i_io_wb  (io_wb),
		.o_rd_val (rd_val),
		.o_rr_val (rr_val)
	);

	alu_sreg u_alu
	(
		.ALU_CLK  (ALU_CLK),
		.hclk     (hclk),
		.i_phase  (o_phase),
		.i_dec    (dec),
		.i_rd_val (rd_val),
		.i_rr_val (rr_val),
		.o_wb     (alu_wb),
		.o_sreg   (o_sreg)
	);

	io_port u_io
	(
		.ALU_CLK  (ALU_CLK),
		.hclk     (hclk),
		.i_phase  (o_phase),
		.i_dec    (dec),
		.i_rd_val (rd_val),
		.i_io_din (i_io_din),
		.o_io     (o_io),
		.o_wb     (io_wb)
	);

endmodule

//--- bench/avr_core_chk.sv
`timescale 1ns/1ps

module avr_core_chk
(
	input logic                     ALU_CLK,
	input logic                     hclk,
	input logic                     i_prog_en,
	input avr_core_pkg::io_bus_t    i_io,
	input avr_core_pkg::phase_e     i_phase
);

	strobe_excl: assert property (@(posedge ALU_CLK) disable iff (hclk)
		!(i_io.wr && i_io.rd))
		else $error("I/O read and write strobes are high together");

	// Write strobe is a single-cycle pulse
	wr_pulse: assert property (@(posedge ALU_CLK) disable iff (hclk)
		i_io.wr |=> !i_io.wr)
		else $error("I/O write strobe held longer than one cycle");

	rd_phase: assert property (@(posedge ALU_CLK) disable iff (hclk)
		i_io.rd |-> (i_phase == avr_core_pkg::PH_IO))
		else $error("I/O read strobe outside the IO phase");

	quiet_load: assert property (@(posedge ALU_CLK) disable iff (hclk)
		i_prog_en |-> (!i_io.wr && !i_io.rd)) // Core is halted while loading
		else $error("I/O strobe raised during program load");

endmodule

bind avr_core_top avr_core_chk u_chk
(
	.ALU_CLK   (ALU_CLK),
	.hclk      (hclk),
	.i_prog_en (i_prog_en),
	.i_io      (o_io),
	.i_phase   (o_phase)
);

//--- bench/tb_avr_core.sv
`timescale 1ns/1ps

module tb_avr_core;

	localparam int N_FIXED = 19;
	localparam int N_RAND  = 4;
	localparam int N_CASES = N_FIXED + N_RAND;
	localparam int TIMEOUT = 200; // Cycles per wait

	typedef struct packed
	{
		avr_isa_pkg::op_e   op;
		logic [7:0]         a;
		logic [7:0]         b;
		logic [7:0]         sreg;
		logic [7:0]         res;
		logic [7:0]         exp_sreg;
	} alu_case_t;

	logic                                 ALU_CLK;
	logic                                 hclk;
	logic                                 i_prog_en;
	logic                                 i_prog_we;
	logic [avr_core_pkg::PC_W-1:0]        i_prog_addr;
	logic [avr_core_pkg::INSTR_W-1:0]     i_prog_data;
	logic [avr_core_pkg::DATA_W-1:0]      i_io_din;
	avr_core_pkg::io_bus_t                io_bus;
	logic [avr_core_pkg::DATA_W-1:0]      sreg;
	logic [avr_core_pkg::PC_W-1:0]        pc;
	avr_core_pkg::phase_e                 phase;

	alu_case_t   cases [N_CASES];
	logic [15:0] prog [16];
	int          prog_len;
	int          errors;
	int          checks;
	integer      seed;

	avr_core_top dut
	(
		.ALU_CLK     (ALU_CLK),
		.hclk        (hclk),
		.i_prog_en   (i_prog_en),
		.i_prog_we   (i_prog_we),
		.i_prog_addr (i_prog_addr),
		.i_prog_data (i_prog_data),
		.i_io_din    (i_io_din),
		.o_io        (io_bus),
		.o_sreg      (sreg),
		.o_pc        (pc),
		.o_phase     (phase)
	);

	always #50 ALU_CLK = ~ALU_CLK;

	function automatic logic [15:0] ldi_word(input logic [4:0] d, input logic [7:0] k);
		return avr_isa_pkg::ENC_LDI | {4'h0, k[7:4], d[3:0], k[3:0]}; // d is r16..r31
	endfunction

	function automatic logic [15:0] rr_word(input logic [15:0] base, input logic [4:0] d,
		input logic [4:0] r);
		return base | {6'b0, r[4], d, r[3:0]};
	endfunction

	function automatic logic [15:0] single_word(input logic [15:0] base, input logic [4:0] d);
		return base | {7'b0, d, 4'b0};
	endfunction

	function automatic logic [15:0] out_word(input logic [5:0] a, input logic [4:0] r);
		return avr_isa_pkg::ENC_OUT | {5'b0, a[5:4], r, a[3:0]};
	endfunction

	function automatic logic [15:0] in_word(input logic [4:0] d, input logic [5:0] a);
		return avr_isa_pkg::ENC_IN | {5'b0, a[5:4], d, a[3:0]};
	endfunction

	function automatic logic [15:0] rjmp_word(input logic [11:0] k);
		return avr_isa_pkg::ENC_RJMP | {4'b0, k};
	endfunction

	function automatic logic [15:0] branch_word(input logic clr, input logic [2:0] s,
		input logic [6:0] k);
		return (clr ? avr_isa_pkg::ENC_BRBC : avr_isa_pkg::ENC_BRBS) | {6'b0, k, s};
	endfunction

	function automatic logic [15:0] opcode_base(input avr_isa_pkg::op_e op);
		case (op)
			avr_isa_pkg::OP_ADD: return avr_isa_pkg::ENC_ADD;
			avr_isa_pkg::OP_ADC: return avr_isa_pkg::ENC_ADC;
			avr_isa_pkg::OP_SUB: return avr_isa_pkg::ENC_SUB;
			avr_isa_pkg::OP_SBC: return avr_isa_pkg::ENC_SBC;
			avr_isa_pkg::OP_AND: return avr_isa_pkg::ENC_AND;
			avr_isa_pkg::OP_OR:  return avr_isa_pkg::ENC_OR;
			avr_isa_pkg::OP_EOR: return avr_isa_pkg::ENC_EOR;
			avr_isa_pkg::OP_MOV: return avr_isa_pkg::ENC_MOV;
			avr_isa_pkg::OP_INC: return avr_isa_pkg::ENC_INC;
			avr_isa_pkg::OP_DEC: return avr_isa_pkg::ENC_DEC;
			default:             return 16'h0000;
		endcase
	endfunction

	// Expected {result, SREG} of add and subtract per the datasheet flag equations
	function automatic logic [15:0] ref_arith(input avr_isa_pkg::op_e op, input logic [7:0] a,
		input logic [7:0] b, input logic [7:0] s);
		int         cin;
		int         full;
		int         half;
		logic [7:0] r;
		logic [7:0] f;
		logic       v;
		logic       is_add;
		is_add = (op == avr_isa_pkg::OP_ADD) || (op == avr_isa_pkg::OP_ADC);
		cin = (op == avr_isa_pkg::OP_ADC || op == avr_isa_pkg::OP_SBC) ? int'(s[0]) : 0;
		f = s;
		if (is_add)
		begin
			full = int'(a) + int'(b) + cin;
			half = int'(a[3:0]) + int'(b[3:0]) + cin;
			r = full[7:0];
			f[avr_isa_pkg::SREG_C] = (full > 255);
			f[avr_isa_pkg::SREG_H] = (half > 15);
			v = (a[7] & b[7] & ~r[7]) | (~a[7] & ~b[7] & r[7]);
		end
		else
		begin
			full = int'(a) - int'(b) - cin;
			half = int'(a[3:0]) - int'(b[3:0]) - cin;
			r = full[7:0];
			f[avr_isa_pkg::SREG_C] = (full < 0);
			f[avr_isa_pkg::SREG_H] = (half < 0);
			v = (a[7] & ~b[7] & ~r[7]) | (~a[7] & b[7] & r[7]);
		end
		f[avr_isa_pkg::SREG_V] = v;
		f[avr_isa_pkg::SREG_N] = r[7];
		f[avr_isa_pkg::SREG_S] = r[7] ^ v;
		f[avr_isa_pkg::SREG_Z] = (r == 8'h00) && (op != avr_isa_pkg::OP_SBC || s[1]);
		return {r, f};
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp)
		begin
			$display("FAIL time=%0t %s expected %02h got %02h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic build_table();
		int         r;
		logic [1:0] sel;
		// op, A, B, SREG in, result, SREG out
		cases[0]  = '{avr_isa_pkg::OP_ADD, 8'h7F, 8'h01, 8'h00, 8'h80, 8'h2C};
		cases[1]  = '{avr_isa_pkg::OP_ADD, 8'hFF, 8'h01, 8'h00, 8'h00, 8'h23};
		cases[2]  = '{avr_isa_pkg::OP_ADC, 8'h10, 8'h20, 8'h01, 8'h31, 8'h00};
		cases[3]  = '{avr_isa_pkg::OP_ADC, 8'hFF, 8'h00, 8'h01, 8'h00, 8'h23};
		cases[4]  = '{avr_isa_pkg::OP_SUB, 8'h00, 8'h01, 8'h00, 8'hFF, 8'h35};
		cases[5]  = '{avr_isa_pkg::OP_SUB, 8'h80, 8'h01, 8'h00, 8'h7F, 8'h38};
		cases[6]  = '{avr_isa_pkg::OP_SBC, 8'h05, 8'h05, 8'h02, 8'h00, 8'h02}; // Z sticky
		cases[7]  = '{avr_isa_pkg::OP_SBC, 8'h05, 8'h05, 8'h00, 8'h00, 8'h00};
		cases[8]  = '{avr_isa_pkg::OP_SBC, 8'h05, 8'h04, 8'h03, 8'h00, 8'h02};
		cases[9]  = '{avr_isa_pkg::OP_SBC, 8'h00, 8'h00, 8'h01, 8'hFF, 8'h35};
		cases[10] = '{avr_isa_pkg::OP_AND, 8'hF0, 8'h3C, 8'h29, 8'h30, 8'h21};
		cases[11] = '{avr_isa_pkg::OP_OR,  8'h80, 8'h01, 8'h00, 8'h81, 8'h14};
		cases[12] = '{avr_isa_pkg::OP_EOR, 8'hA5, 8'hA5, 8'h21, 8'h00, 8'h23};
		cases[13] = '{avr_isa_pkg::OP_MOV, 8'h11, 8'h9C, 8'h5A, 8'h9C, 8'h5A};
		cases[14] = '{avr_isa_pkg::OP_INC, 8'h7F, 8'h00, 8'h01, 8'h80, 8'h0D};
		cases[15] = '{avr_isa_pkg::OP_INC, 8'hFF, 8'h00, 8'h20, 8'h00, 8'h22};
		cases[16] = '{avr_isa_pkg::OP_DEC, 8'h80, 8'h00, 8'h00, 8'h7F, 8'h18};
		cases[17] = '{avr_isa_pkg::OP_DEC, 8'h01, 8'h00, 8'h21, 8'h00, 8'h23};
		cases[18] = '{avr_isa_pkg::OP_ADD, 8'h01, 8'h02, 8'hC0, 8'h03, 8'hC0}; // I and T kept
		for (int i = N_FIXED; i < N_CASES; i++)
		begin
			r = $random(seed);
			sel = r[1:0];
			case (sel)
				2'd0:    cases[i].op = avr_isa_pkg::OP_ADD;
				2'd1:    cases[i].op = avr_isa_pkg::OP_ADC;
				2'd2:    cases[i].op = avr_isa_pkg::OP_SUB;
				default: cases[i].op = avr_isa_pkg::OP_SBC;
			endcase
			cases[i].a = r[15:8];
			cases[i].b = r[23:16];
			cases[i].sreg = r[31:24];
			{cases[i].res, cases[i].exp_sreg} =
				ref_arith(cases[i].op, cases[i].a, cases[i].b, cases[i].sreg);
		end
	endtask

	task automatic put_word(input logic [15:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic load_program();
		@(posedge ALU_CLK);
		i_prog_en <= 1'b1;
		for (int i = 0; i < prog_len; i++)
		begin
			@(posedge ALU_CLK);
			i_prog_we   <= 1'b1;
			i_prog_addr <= avr_core_pkg::PC_W'(i);
			i_prog_data <= prog[i];
		end
		@(posedge ALU_CLK);
		i_prog_we <= 1'b0;
		@(posedge ALU_CLK);
		i_prog_en <= 1'b0; // Core starts on the next cycle
	endtask

	task automatic wait_for_write(input logic [7:0] exp_dout, input logic need_rd,
		output logic got);
		logic saw_rd;
		got = 1'b0;
		saw_rd = 1'b0;
		for (int n = 0; n < TIMEOUT && !got; n++)
		begin
			@(negedge ALU_CLK);
			if (io_bus.rd)
			begin
				saw_rd = 1'b1;
				check_byte("o_io.addr", 8'h05, {2'b00, io_bus.addr});
				check_byte("o_phase", {6'b0, avr_core_pkg::PH_IO}, {6'b0, phase});
			end
			if (io_bus.wr)
				got = 1'b1;
		end
		if (!got)
		begin
			$display("ERROR time=%0t no I/O write within %0d cycles", $time, TIMEOUT);
			errors++;
		end
		else
		begin
			check_byte("o_io.addr", 8'h10, {2'b00, io_bus.addr}); // First write is never SREG
			check_byte("o_io.dout", exp_dout, io_bus.dout);
			// Strobe cycle after EXEC is the next fetch
			check_byte("o_phase", {6'b0, avr_core_pkg::PH_FETCH}, {6'b0, phase});
			if (need_rd && !saw_rd)
			begin
				$display("ERROR time=%0t IN finished without an I/O read strobe", $time);
				errors++;
			end
		end
	endtask

	task automatic apply_alu_case(input alu_case_t c);
		logic got;
		prog_len = 0;
		put_word(ldi_word(5'd16, c.a));
		put_word(ldi_word(5'd17, c.b));
		put_word(ldi_word(5'd18, c.sreg));
		put_word(out_word(avr_isa_pkg::IO_SREG_ADDR, 5'd18));
		if (c.op == avr_isa_pkg::OP_INC || c.op == avr_isa_pkg::OP_DEC)
			put_word(single_word(opcode_base(c.op), 5'd16));
		else
			put_word(rr_word(opcode_base(c.op), 5'd16, 5'd17));
		put_word(out_word(6'h10, 5'd16));
		put_word(rjmp_word(12'hFFF)); // Jump to itself
		load_program();
		wait_for_write(c.res, 1'b0, got);
		if (got)
			check_byte("o_sreg", c.exp_sreg, sreg);
	endtask

	// Taken path outputs 0x01 and fall-through 0x02
	task automatic branch_on_zero(input logic clr, input logic z);
		logic       got;
		logic       taken;
		logic [7:0] s;
		s = z ? 8'h02 : 8'h00;
		taken = clr ? !z : z;
		prog_len = 0;
		put_word(ldi_word(5'd18, s));
		put_word(out_word(avr_isa_pkg::IO_SREG_ADDR, 5'd18));
		put_word(branch_word(clr, 3'd1, 7'd3)); // Target is word 6
		put_word(ldi_word(5'd19, 8'h02));
		put_word(out_word(6'h10, 5'd19));
		put_word(rjmp_word(12'hFFF));
		put_word(ldi_word(5'd19, 8'h01));
		put_word(out_word(6'h10, 5'd19));
		put_word(rjmp_word(12'hFFF));
		load_program();
		wait_for_write(taken ? 8'h01 : 8'h02, 1'b0, got);
		if (got)
			check_byte("o_sreg", s, sreg);
	endtask

	task automatic echo_io_input();
		logic       got;
		logic [7:0] din;
		int         r;
		r = $random(seed);
		din = r[7:0];
		@(posedge ALU_CLK);
		i_io_din <= din;
		prog_len = 0;
		put_word(in_word(5'd20, 6'h05));
		put_word(out_word(6'h10, 5'd20));
		put_word(rjmp_word(12'hFFF));
		load_program();
		wait_for_write(din, 1'b1, got);
	endtask

	initial
	begin
		ALU_CLK     = 1'b0;
		hclk        = 1'b1;
		i_prog_en   = 1'b0;
		i_prog_we   = 1'b0;
		i_prog_addr = '0;
		i_prog_data = '0;
		i_io_din    = '0;
		seed        = 32'h8eef;
		errors      = 0;
		checks      = 0;
		prog_len    = 0;
		build_table();
		repeat (16) @(posedge ALU_CLK);
		hclk <= 1'b0;
		@(negedge ALU_CLK);
		check_byte("o_sreg", 8'h00, sreg);
		check_byte("o_pc", 8'h00, pc[7:0]);
		check_byte("o_phase", {6'b0, avr_core_pkg::PH_FETCH}, {6'b0, phase});
		for (int i = 0; i < N_CASES; i++)
			apply_alu_case(cases[i]);
		branch_on_zero(1'b0, 1'b1);
		branch_on_zero(1'b0, 1'b0);
		branch_on_zero(1'b1, 1'b1);
		branch_on_zero(1'b1, 1'b0);
		echo_io_input();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- build.f
design/avr_isa_pkg.sv
design/avr_core_pkg.sv
design/prog_rom.sv
design/fetch_ctrl.sv
design/instr_decode.sv
design/reg_file.sv
design/alu_sreg.sv
design/io_port.sv
design/avr_core_top.sv
bench/avr_core_chk.sv
bench/tb_avr_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_avr_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
